//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= stb_top.f
TB_TOP    ?= tb_stb_top
RTL_TOP   ?= stb_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

RTL_FILES := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/stb_bus_mux.sv
module stb_bus_mux (
  input  logic                stb_clk,
  input  logic                cpurst_b,
  input  stb_pkg::entry_vec_t biu_sel,
  input  logic                bus_grant,
  input  stb_pkg::addr_t      entry_addr  [stb_pkg::STB_ENTRIES],
  input  stb_pkg::data_t      entry_data  [stb_pkg::STB_ENTRIES],
  input  stb_pkg::bytes_t     entry_bytes [stb_pkg::STB_ENTRIES],
  input  stb_pkg::size_t      entry_size  [stb_pkg::STB_ENTRIES],
  output stb_pkg::addr_t      bus_addr,
  output stb_pkg::size_t      bus_size,
  output stb_pkg::bytes_t     bus_bytes_vld,
  output stb_pkg::data_t      bus_wdata
);
  import stb_pkg::*;

  entry_vec_t wdata_sel;

  // Address phase follows the live select
  always_comb
  begin
    bus_addr      = '0;
    bus_size      = '0;
    bus_bytes_vld = '0;
    for (int i = 0; i < STB_ENTRIES; i++)
    begin
      if (biu_sel[i])
      begin
        bus_addr      = bus_addr | entry_addr[i];
        bus_size      = bus_size | entry_size[i];
        bus_bytes_vld = bus_bytes_vld | entry_bytes[i];
      end
    end
  end

  // Data phase entry, held from grant until the next grant
  always_ff @(posedge stb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wdata_sel <= '0;
    else if (bus_grant)
      wdata_sel <= biu_sel;
  end

  always_comb
  begin
    bus_wdata = '0;
    for (int i = 0; i < STB_ENTRIES; i++)
    begin
      if (wdata_sel[i])
        bus_wdata = bus_wdata | entry_data[i];
    end
  end

endmodule

//--- rtl/stb_ctrl.sv
module stb_ctrl (
  input  logic                stb_clk,
  input  logic                cpurst_b,
  input  logic                st_valid,
  input  stb_pkg::entry_vec_t entry_vld,
  input  stb_pkg::entry_vec_t entry_age,
  input  stb_pkg::entry_vec_t entry_bus_req,
  input  logic                bus_grant,
  input  logic                bus_cmplt,
  output logic                st_ready,
  output stb_pkg::entry_vec_t create_en,
  output logic                create_age,
  output stb_pkg::entry_vec_t biu_sel,
  output stb_pkg::entry_vec_t wbus_grant,
  output stb_pkg::entry_vec_t wbus_cmplt,
  output logic                bus_req,
  output logic                stb_idle
);
  import stb_pkg::*;

  logic       create_ptr;
  entry_vec_t ptr_vec;
  entry_vec_t pick_sel;
  entry_vec_t wb_req_sel;
  logic       req_vld;
  logic       wb_sel_open;
  wb_state_t  wb_cur_state;
  wb_state_t  wb_next_state;

  // ==========================================================
  // Create side
  // ==========================================================
  always_ff @(posedge stb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      create_ptr <= 1'b0;
    else if (st_valid & st_ready)
      create_ptr <= ~create_ptr;
  end

  assign ptr_vec    = {create_ptr, ~create_ptr};
  assign st_ready   = ~|(ptr_vec & entry_vld);
  assign create_en  = ptr_vec & {STB_ENTRIES{st_valid & st_ready}};
  // Other entry stays valid past this edge
  assign create_age = |(entry_vld & ~wbus_cmplt);
  assign stb_idle   = ~|entry_vld;

  // ==========================================================
  // Write-bus request
  // ==========================================================
  assign pick_sel[1] = entry_bus_req[1] & (~entry_bus_req[0] | ~entry_age[1]);
  assign pick_sel[0] = entry_bus_req[0] & (~entry_bus_req[1] | ~entry_age[0]);
  assign req_vld     = |entry_bus_req;

  always_ff @(posedge stb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_cur_state <= WB_IDLE;
    else
      wb_cur_state <= wb_next_state;
  end

  always_comb
  begin
    wb_next_state = wb_cur_state;
    case (wb_cur_state)
      WB_IDLE:
        if (req_vld)
          wb_next_state = bus_grant ? WB_WFC : WB_WFG;
      WB_WFG:
        if (bus_grant)
          wb_next_state = WB_WFC;
      WB_WFC:
        if (bus_cmplt & req_vld)
          wb_next_state = bus_grant ? WB_WFC : WB_WFG;
        else if (bus_cmplt)
          wb_next_state = WB_IDLE;
      default:
        wb_next_state = WB_IDLE;
    endcase
  end

  // A fresh pick is taken when idle or as the current write completes
  assign wb_sel_open = (wb_cur_state == WB_IDLE) | ((wb_cur_state == WB_WFC) & bus_cmplt);

  always_ff @(posedge stb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_req_sel <= '0;
    else if (wb_sel_open & req_vld)
      wb_req_sel <= pick_sel;
  end

  assign biu_sel    = wb_sel_open ? pick_sel : wb_req_sel;
  assign bus_req    = |(biu_sel & entry_bus_req) & ((wb_cur_state != WB_WFC) | bus_cmplt);
  assign wbus_grant = biu_sel & {STB_ENTRIES{bus_grant & bus_req}};
  assign wbus_cmplt = wb_req_sel & {STB_ENTRIES{bus_cmplt & (wb_cur_state == WB_WFC)}};

endmodule

//--- rtl/stb_entry.sv
module stb_entry (
  input  logic            stb_clk,
  input  logic            cpurst_b,
  input  logic            create_en,
  input  logic            create_age,
  input  stb_pkg::addr_t  st_addr,
  input  stb_pkg::data_t  st_data,
  input  stb_pkg::bytes_t st_bytes_vld,
  input  stb_pkg::size_t  st_size,
  input  logic            wbus_grant,
  input  logic            wbus_cmplt,
  output logic            entry_vld,
  output logic            entry_age,
  output logic            entry_bus_req,
  output stb_pkg::addr_t  entry_addr,
  output stb_pkg::data_t  entry_data,
  output stb_pkg::bytes_t entry_bytes,
  output stb_pkg::size_t  entry_size
);
  import stb_pkg::*;

  // Granted, now waiting for the bus to finish the write
  logic wait_cmplt;

  always_ff @(posedge stb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_vld  <= 1'b0;
      wait_cmplt <= 1'b0;
    end
    else if (create_en)
    begin
      entry_vld  <= 1'b1;
      wait_cmplt <= 1'b0;
    end
    else if (wbus_cmplt)
    begin
      entry_vld  <= 1'b0;
      wait_cmplt <= 1'b0;
    end
    else if (wbus_grant)
      wait_cmplt <= 1'b1;
  end

  // Set means the other entry holds an older store.
  // Oldest-first drain frees the other entry no later than this grant
  always_ff @(posedge stb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_age <= 1'b0;
    else if (create_en)
      entry_age <= create_age;
    else if (wbus_grant)
      entry_age <= 1'b0;
  end

  always_ff @(posedge stb_clk)
  begin
    if (create_en)
    begin
      entry_addr  <= st_addr;
      entry_data  <= st_data;
      entry_bytes <= st_bytes_vld;
      entry_size  <= st_size;
    end
  end

  assign entry_bus_req = entry_vld & ~wait_cmplt;

endmodule

//--- rtl/stb_fwd.sv
module stb_fwd (
  input  stb_pkg::entry_vec_t entry_vld,
  input  stb_pkg::addr_t      entry_addr  [stb_pkg::STB_ENTRIES],
  input  stb_pkg::bytes_t     entry_bytes [stb_pkg::STB_ENTRIES],
  input  stb_pkg::data_t      entry_data  [stb_pkg::STB_ENTRIES],
  input  stb_pkg::addr_t      ld_addr,
  input  stb_pkg::bytes_t     ld_bytes_vld,
  output logic                ld_fwd_vld,
  output stb_pkg::data_t      ld_fwd_data,
  output logic                ld_multi_or_part_hit
);
  import stb_pkg::*;

  entry_vec_t addr_hit;
  entry_vec_t full_hit;
  entry_vec_t part_hit;

  // Word match, then byte coverage
  always_comb
  begin
    for (int i = 0; i < STB_ENTRIES; i++)
    begin
      addr_hit[i] = entry_vld[i] &
                    (entry_addr[i][ADDR_W-1:WORD_LSB] == ld_addr[ADDR_W-1:WORD_LSB]);
      full_hit[i] = addr_hit[i] & ((ld_bytes_vld & ~entry_bytes[i]) == '0);
      part_hit[i] = addr_hit[i] & ~full_hit[i] & (|(ld_bytes_vld & entry_bytes[i]));
    end
  end

  always_comb
  begin
    ld_fwd_data = '0;
    for (int i = 0; i < STB_ENTRIES; i++)
    begin
      if (full_hit[i])
        ld_fwd_data = ld_fwd_data | entry_data[i];
    end
  end

  assign ld_fwd_vld           = |full_hit;
  // Both entries covering the load is treated like a partial hit
  assign ld_multi_or_part_hit = (|part_hit) | (&full_hit);

endmodule

//--- rtl/stb_pkg.sv
package stb_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================
  localparam int STB_ENTRIES = 2;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int BYTES_W     = DATA_W / 8;

  // Low address bits below word granularity
  localparam int WORD_LSB    = $clog2(BYTES_W);

  // ==========================================================
  // Field types
  // ==========================================================
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [BYTES_W-1:0]     bytes_t;

  // 0 byte, 1 half, 2 word
  typedef logic [1:0]             size_t;

  // One bit per entry
  typedef logic [STB_ENTRIES-1:0] entry_vec_t;

  // Write-bus handshake state
  typedef enum logic [1:0] {
    WB_IDLE = 2'b00,
    WB_WFG  = 2'b01,
    WB_WFC  = 2'b10
  } wb_state_t;

endpackage

//--- rtl/stb_top.sv
module stb_top (
  input  logic            stb_clk,
  input  logic            cpurst_b,
  input  logic            st_valid,
  input  stb_pkg::addr_t  st_addr,
  input  stb_pkg::data_t  st_data,
  input  stb_pkg::bytes_t st_bytes_vld,
  input  stb_pkg::size_t  st_size,
  output logic            st_ready,
  output logic            bus_req,
  output stb_pkg::addr_t  bus_addr,
  output stb_pkg::size_t  bus_size,
  output stb_pkg::bytes_t bus_bytes_vld,
  output stb_pkg::data_t  bus_wdata,
  input  logic            bus_grant,
  input  logic            bus_cmplt,
  input  stb_pkg::addr_t  ld_addr,
  input  stb_pkg::bytes_t ld_bytes_vld,
  output logic            ld_fwd_vld,
  output stb_pkg::data_t  ld_fwd_data,
  output logic            ld_multi_or_part_hit,
  output logic            stb_idle
);
  import stb_pkg::*;

  entry_vec_t create_en;
  logic       create_age;
  entry_vec_t wbus_grant;
  entry_vec_t wbus_cmplt;
  entry_vec_t entry_vld;
  entry_vec_t entry_age;
  entry_vec_t entry_bus_req;
  entry_vec_t biu_sel;
  addr_t      entry_addr  [STB_ENTRIES];
  data_t      entry_data  [STB_ENTRIES];
  bytes_t     entry_bytes [STB_ENTRIES];
  size_t      entry_size  [STB_ENTRIES];

  // ==========================================================
  // Entries
  // ==========================================================
  for (genvar i = 0; i < STB_ENTRIES; i++)
  begin : g_entry
    stb_entry x_stb_entry (
      .stb_clk       (stb_clk),
      .cpurst_b      (cpurst_b),
      .create_en     (create_en[i]),
      .create_age    (create_age),
      .st_addr       (st_addr),
      .st_data       (st_data),
      .st_bytes_vld  (st_bytes_vld),
      .st_size       (st_size),
      .wbus_grant    (wbus_grant[i]),
      .wbus_cmplt    (wbus_cmplt[i]),
      .entry_vld     (entry_vld[i]),
      .entry_age     (entry_age[i]),
      .entry_bus_req (entry_bus_req[i]),
      .entry_addr    (entry_addr[i]),
      .entry_data    (entry_data[i]),
      .entry_bytes   (entry_bytes[i]),
      .entry_size    (entry_size[i])
    );
  end

  stb_ctrl x_stb_ctrl (
    .stb_clk       (stb_clk),
    .cpurst_b      (cpurst_b),
    .st_valid      (st_valid),
    .entry_vld     (entry_vld),
    .entry_age     (entry_age),
    .entry_bus_req (entry_bus_req),
    .bus_grant     (bus_grant),
    .bus_cmplt     (bus_cmplt),
    .st_ready      (st_ready),
    .create_en     (create_en),
    .create_age    (create_age),
    .biu_sel       (biu_sel),
    .wbus_grant    (wbus_grant),
    .wbus_cmplt    (wbus_cmplt),
    .bus_req       (bus_req),
    .stb_idle      (stb_idle)
  );

  stb_bus_mux x_stb_bus_mux (
    .stb_clk       (stb_clk),
    .cpurst_b      (cpurst_b),
    .biu_sel       (biu_sel),
    .bus_grant     (bus_grant),
    .entry_addr    (entry_addr),
    .entry_data    (entry_data),
    .entry_bytes   (entry_bytes),
    .entry_size    (entry_size),
    .bus_addr      (bus_addr),
    .bus_size      (bus_size),
    .bus_bytes_vld (bus_bytes_vld),
    .bus_wdata     (bus_wdata)
  );

  stb_fwd x_stb_fwd (
    .entry_vld            (entry_vld),
    .entry_addr           (entry_addr),
    .entry_bytes          (entry_bytes),
    .entry_data           (entry_data),
    .ld_addr              (ld_addr),
    .ld_bytes_vld         (ld_bytes_vld),
    .ld_fwd_vld           (ld_fwd_vld),
    .ld_fwd_data          (ld_fwd_data),
    .ld_multi_or_part_hit (ld_multi_or_part_hit)
  );

endmodule

//--- stb_top.f
rtl/stb_pkg.sv
rtl/stb_entry.sv
rtl/stb_ctrl.sv
rtl/stb_fwd.sv
rtl/stb_bus_mux.sv
rtl/stb_top.sv
tests/tb_stb_bus_model.sv
tests/tb_stb_top.sv

//--- tests/tb_stb_bus_model.sv
module tb_stb_bus_model (
  input  logic            stb_clk,
  input  logic            cpurst_b,
  input  logic            hold_grant,
  input  logic [3:0]      grant_dly,
  input  logic [3:0]      cmplt_dly,
  input  logic            bus_req,
  input  stb_pkg::addr_t  bus_addr,
  input  stb_pkg::size_t  bus_size,
  input  stb_pkg::bytes_t bus_bytes_vld,
  input  stb_pkg::data_t  bus_wdata,
  output logic            bus_grant,
  output logic            bus_cmplt,
  output logic            wr_done,
  output stb_pkg::addr_t  wr_addr,
  output stb_pkg::size_t  wr_size,
  output stb_pkg::bytes_t wr_bytes,
  output stb_pkg::data_t  wr_data
);
  import stb_pkg::*;

  logic       busy;
  logic [3:0] cnt;

  initial
  begin
    bus_grant = 1'b0;
    bus_cmplt = 1'b0;
    wr_done   = 1'b0;
    wr_addr   = '0;
    wr_size   = '0;
    wr_bytes  = '0;
    wr_data   = '0;
    busy      = 1'b0;
    cnt       = '0;
  end

  // Responses change on the falling edge only
  always @(negedge stb_clk)
  begin
    bus_grant = 1'b0;
    bus_cmplt = 1'b0;
    wr_done   = 1'b0;
    if (!cpurst_b)
    begin
      busy = 1'b0;
      cnt  = '0;
    end
    else if (!busy)
    begin
      if (bus_req && !hold_grant)
      begin
        if (cnt == 0)
        begin
          bus_grant = 1'b1;
          wr_addr   = bus_addr;
          wr_size   = bus_size;
          wr_bytes  = bus_bytes_vld;
          busy      = 1'b1;
          cnt       = cmplt_dly;
        end
        else
          cnt = cnt - 1;
      end
    end
    else if (cnt == 0)
    begin
      // Data phase is valid from the cycle after the grant
      bus_cmplt = 1'b1;
      wr_done   = 1'b1;
      wr_data   = bus_wdata;
      busy      = 1'b0;
      cnt       = grant_dly;
    end
    else
      cnt = cnt - 1;
  end

endmodule

//--- tests/tb_stb_top.sv
module tb_stb_top;
  import stb_pkg::*;

  localparam int NUM_STORES = 12;
  localparam int MAX_DLY    = 5;
  localparam int CYC_LIMIT  = (NUM_STORES + 3) * (2 * MAX_DLY + 4) + 100;

  logic stb_clk;
  logic cpurst_b;
  logic st_valid;
  addr_t st_addr;
  data_t st_data;
  bytes_t st_bytes_vld;
  size_t st_size;
  logic st_ready;
  logic bus_req;
  addr_t bus_addr;
  size_t bus_size;
  bytes_t bus_bytes_vld;
  data_t bus_wdata;
  logic bus_grant;
  logic bus_cmplt;
  addr_t ld_addr;
  bytes_t ld_bytes_vld;
  logic ld_fwd_vld;
  data_t ld_fwd_data;
  logic ld_multi_or_part_hit;
  logic stb_idle;
  logic hold_grant;
  logic [3:0] grant_dly;
  logic [3:0] cmplt_dly;
  logic wr_done;
  addr_t wr_addr;
  size_t wr_size;
  bytes_t wr_bytes;
  data_t wr_data;

  // Model of the buffered stores in acceptance order
  addr_t  q_addr[$];
  data_t  q_data[$];
  bytes_t q_bytes[$];
  size_t  q_size[$];

  logic [31:0] rnd_seed;
  logic [31:0] dly_seed;
  int err_cnt;
  int chk_cnt;
  int test_cnt;
  int test_fail;
  int cyc;

  stb_top dut0 (.*);

  tb_stb_bus_model bus0 (.*);

  always #20 stb_clk = ~stb_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Returns {fwd_vld, multi_or_part, fwd_data}
  function automatic logic [33:0] ref_fwd(input addr_t a, input bytes_t b);
    logic   vld;
    logic   part;
    int     nfull;
    data_t  d;
    vld   = 1'b0;
    part  = 1'b0;
    nfull = 0;
    d     = '0;
    for (int i = 0; i < q_addr.size(); i++)
    begin
      if (q_addr[i][31:2] == a[31:2])
      begin
        if ((b & q_bytes[i]) == b)
        begin
          vld   = 1'b1;
          nfull = nfull + 1;
          d     = d | q_data[i];
        end
        else if ((b & q_bytes[i]) != '0)
          part = 1'b1;
      end
    end
    return {vld, part | (nfull > 1), d};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    assert (got == exp)
    else
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before)
      test_fail++;
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "FAIL");
  endtask

  // Starts and ends on a falling edge
  task automatic send_store(input addr_t a, input data_t d, input bytes_t b, input size_t s);
    st_valid     = 1'b1;
    st_addr      = a;
    st_data      = d;
    st_bytes_vld = b;
    st_size      = s;
    while (!st_ready)
      @(negedge stb_clk);
    q_addr.push_back(a);
    q_data.push_back(d);
    q_bytes.push_back(b);
    q_size.push_back(s);
    @(negedge stb_clk);
    st_valid = 1'b0;
  endtask

  task automatic probe_load(input addr_t a, input bytes_t b);
    logic [33:0] exp;
    ld_addr      = a;
    ld_bytes_vld = b;
    exp          = ref_fwd(a, b);
    @(negedge stb_clk);
    check_value("ld_fwd_vld", ld_fwd_vld, exp[33]);
    check_value("ld_multi_or_part_hit", ld_multi_or_part_hit, exp[32]);
    check_value("ld_fwd_data", ld_fwd_data, exp[31:0]);
  endtask

  // ==========================================================
  // Bus write compare and random delays
  // ==========================================================
  always @(posedge stb_clk)
  begin
    if (cpurst_b && wr_done)
    begin
      chk_cnt++;
      assert (q_addr.size() != 0)
      else
      begin
        $display("bus completed a write with no store buffered");
        err_cnt++;
      end
      if (q_addr.size() != 0)
      begin
        check_value("bus_addr", wr_addr, q_addr.pop_front());
        check_value("bus_wdata", wr_data, q_data.pop_front());
        check_value("bus_bytes_vld", wr_bytes, q_bytes.pop_front());
        check_value("bus_size", wr_size, q_size.pop_front());
      end
    end
  end

  always @(negedge stb_clk)
  begin
    dly_seed  = lcg_next(dly_seed);
    grant_dly <= 4'(dly_seed[31:16] % (MAX_DLY + 1));
    cmplt_dly <= 4'(dly_seed[15:8] % (MAX_DLY + 1));
  end

  always @(posedge stb_clk)
  begin
    cyc++;
    if (cyc > CYC_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  // ==========================================================
  // Stimulus
  // ==========================================================
  initial
  begin
    int    e0;
    stb_clk      = 1'b0;
    cpurst_b     = 1'b0;
    st_valid     = 1'b0;
    st_addr      = '0;
    st_data      = '0;
    st_bytes_vld = '0;
    st_size      = '0;
    ld_addr      = 32'hffff_fff0;
    ld_bytes_vld = '0;
    hold_grant   = 1'b1;
    grant_dly    = '0;
    cmplt_dly    = '0;
    rnd_seed     = 32'hfca5;
    dly_seed     = ~32'hfca5;
    err_cnt      = 0;
    chk_cnt      = 0;
    test_cnt     = 0;
    test_fail    = 0;
    cyc          = 0;
    repeat (3) @(negedge stb_clk);
    cpurst_b = 1'b1;
    @(negedge stb_clk);

    e0 = err_cnt;
    check_value("st_ready", st_ready, 1);
    check_value("bus_req", bus_req, 0);
    check_value("stb_idle", stb_idle, 1);
    check_value("ld_fwd_vld", ld_fwd_vld, 0);
    check_value("ld_multi_or_part_hit", ld_multi_or_part_hit, 0);
    end_test("reset state", e0);

    e0 = err_cnt;
    hold_grant <= 1'b0;
    for (int n = 0; n < NUM_STORES; n++)
    begin
      addr_t a;
      data_t d;
      rnd_seed = lcg_next(rnd_seed);
      a        = rnd_seed;
      rnd_seed = lcg_next(rnd_seed);
      d        = rnd_seed;
      rnd_seed = lcg_next(rnd_seed);
      send_store(a, d, 4'(rnd_seed[19:16] | 4'b0001), 2'(rnd_seed[25:24] % 3));
    end
    while (q_addr.size() != 0)
      @(negedge stb_clk);
    end_test("in-order drain", e0);

    e0 = err_cnt;
    hold_grant <= 1'b1;
    send_store(32'h0000_0100, 32'h1122_3344, 4'b1111, 2'd2);
    send_store(32'h0000_0102, 32'h5566_0000, 4'b1100, 2'd1);
    st_valid     = 1'b1;
    st_addr      = 32'h0000_0200;
    st_data      = 32'h0000_00a5;
    st_bytes_vld = 4'b0001;
    st_size      = 2'd0;
    repeat (6)
    begin
      @(negedge stb_clk);
      check_value("st_ready", st_ready, 0);
      check_value("bus_req", bus_req, 1);
      // Oldest store stays on the request
      check_value("bus_addr", bus_addr, 32'h0000_0100);
    end
    end_test("back-pressure", e0);

    e0 = err_cnt;
    probe_load(32'h0000_0100, 4'b0011);
    probe_load(32'h0000_0103, 4'b0001);
    end_test("full-hit forwarding", e0);

    e0 = err_cnt;
    probe_load(32'h0000_0100, 4'b0110);
    probe_load(32'h0000_0100, 4'b1100);
    probe_load(32'h0000_0300, 4'b1111);
    end_test("partial or multiple hit", e0);

    e0 = err_cnt;
    hold_grant <= 1'b0;
    send_store(32'h0000_0200, 32'h0000_00a5, 4'b0001, 2'd0);
    while (q_addr.size() != 0)
      @(negedge stb_clk);
    @(negedge stb_clk);
    check_value("stb_idle", stb_idle, 1);
    check_value("st_ready", st_ready, 1);
    end_test("idle after drain", e0);

    $display("tests %0d failed %0d checks %0d errors %0d", test_cnt, test_fail, chk_cnt,
             err_cnt);
    if (err_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
